// File: hdl/mmu_pkg.sv
// --------------------
// shared widths, types and cause codes of the SV39 data MMU
// every RTL file refers to these by scoped name
// --------------------
package mmu_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int unsigned VADDR_W       = 64;
    localparam int unsigned PADDR_W       = 56;
    localparam int unsigned PAGE_OFFSET_W = 12;
    localparam int unsigned VPN_LEVEL_W   = 9;
    // three levels in SV39
    localparam int unsigned VPN_W         = 3 * VPN_LEVEL_W;
    localparam int unsigned PPN_W         = PADDR_W - PAGE_OFFSET_W;
    localparam int unsigned ASID_W        = 16;
    localparam int unsigned CAUSE_W       = 6;

    // --------------------
    // address types
    // --------------------
    // virtual address as the LSU presents it
    typedef logic [VADDR_W-1:0] vaddr_t;
    typedef logic [PADDR_W-1:0] paddr_t;
    typedef logic [VPN_W-1:0]   vpn_t;
    typedef logic [PPN_W-1:0]   ppn_t;
    // top level may compare fewer bits through its parameter
    typedef logic [ASID_W-1:0]  asid_t;

    // sv39 leaf entry without the reserved and rsw fields
    typedef struct packed {
        ppn_t ppn;
        logic d;
        logic a;
        logic g;
        logic u;
        logic x;
        logic w;
        logic r;
        logic v;
    } pte_t;

    // encoding follows the privileged spec
    typedef enum logic [1:0] {
        PRIV_LVL_U = 2'b00,
        PRIV_LVL_S = 2'b01,
        PRIV_LVL_M = 2'b11
    } priv_lvl_t;

    // --------------------
    // exception causes
    // --------------------
    typedef logic [CAUSE_W-1:0] cause_t;

    localparam cause_t LOAD_ADDR_MISALIGNED  = 6'd4;
    localparam cause_t STORE_ADDR_MISALIGNED = 6'd6;
    localparam cause_t LOAD_PAGE_FAULT       = 6'd13;
    localparam cause_t STORE_PAGE_FAULT      = 6'd15;

endpackage

// File: hdl/tlb_lookup_if.sv
// --------------------
// lookup request into the data TLB and its same-cycle result
// --------------------
`timescale 1ns/10ps

interface tlb_lookup_if;

    // request side, driven by the top level
    logic            access;
    mmu_pkg::vaddr_t vaddr;
    mmu_pkg::asid_t  asid;

    // result side, combinational from the request
    logic            hit;
    mmu_pkg::pte_t   pte;
    logic            is_2m;
    logic            is_1g;

    // tlb answers the request
    modport tlb (
        input  access, vaddr, asid,
        output hit, pte, is_2m, is_1g
    );

    // translation stage only looks at the answer
    modport stage (
        input  hit, pte, is_2m, is_1g
    );

endinterface

// File: hdl/dtlb.sv
// --------------------
// fully associative data TLB with 4K/2M/1G pages and ASID tags
// written by an external refill strobe and cleared by flush
// --------------------
`timescale 1ns/10ps

module dtlb #(
    parameter int unsigned DTLB_ENTRIES = 4,
    parameter int unsigned ASID_WIDTH   = 16
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_tlb_i,
    input  logic                 update_valid_i,
    input  mmu_pkg::vpn_t        update_vpn_i,
    input  mmu_pkg::asid_t       update_asid_i,
    input  mmu_pkg::pte_t        update_pte_i,
    input  logic                 update_is_2m_i,
    input  logic                 update_is_1g_i,
    tlb_lookup_if.tlb            lookup
);

    localparam int unsigned IDX_W = (DTLB_ENTRIES > 1) ? $clog2(DTLB_ENTRIES) : 1;
    localparam int unsigned LVL_W = mmu_pkg::VPN_LEVEL_W;
    localparam int unsigned VPN_W = mmu_pkg::VPN_W;
    localparam int unsigned OFS_W = mmu_pkg::PAGE_OFFSET_W;

    // --------------------
    // entry storage
    // --------------------
    logic [DTLB_ENTRIES-1:0] valid_q;
    mmu_pkg::vpn_t           tag_vpn_q  [DTLB_ENTRIES];
    mmu_pkg::asid_t          tag_asid_q [DTLB_ENTRIES];
    logic                    tag_2m_q   [DTLB_ENTRIES];
    logic                    tag_1g_q   [DTLB_ENTRIES];
    mmu_pkg::pte_t           pte_q      [DTLB_ENTRIES];

    // replacement state
    logic [IDX_W-1:0]        rr_ptr_q;
    logic [IDX_W-1:0]        free_idx;
    logic                    has_free;
    logic [IDX_W-1:0]        wr_idx;

    logic [DTLB_ENTRIES-1:0] match;
    mmu_pkg::vpn_t           lu_vpn;

    // vpn bits of the incoming virtual address
    assign lu_vpn = lookup.vaddr[OFS_W+VPN_W-1:OFS_W];

    // --------------------
    // tag compare
    // --------------------
    for (genvar i = 0; i < DTLB_ENTRIES; i++) begin : g_match
        logic asid_ok;
        logic lvl2_ok;
        logic lvl1_ok;
        logic lvl0_ok;

        // global pages ignore the address space
        assign asid_ok = (tag_asid_q[i][ASID_WIDTH-1:0] == lookup.asid[ASID_WIDTH-1:0])
                       || pte_q[i].g;
        // top level is always compared
        assign lvl2_ok = tag_vpn_q[i][VPN_W-1 -: LVL_W] == lu_vpn[VPN_W-1 -: LVL_W];
        // middle level skipped for a gigapage
        assign lvl1_ok = tag_1g_q[i]
                       || (tag_vpn_q[i][2*LVL_W-1 -: LVL_W] == lu_vpn[2*LVL_W-1 -: LVL_W]);
        // lowest level only matters for a 4K page
        assign lvl0_ok = tag_1g_q[i] || tag_2m_q[i]
                       || (tag_vpn_q[i][LVL_W-1:0] == lu_vpn[LVL_W-1:0]);
        assign match[i] = valid_q[i] && asid_ok && lvl2_ok && lvl1_ok && lvl0_ok;
    end

    // the single matching entry drives the result
    always_comb begin
        lookup.hit   = 1'b0;
        lookup.pte   = '0;
        lookup.is_2m = 1'b0;
        lookup.is_1g = 1'b0;
        for (int i = 0; i < DTLB_ENTRIES; i++) begin
            if (match[i]) begin
                lookup.hit   = lookup.access;
                lookup.pte   = pte_q[i];
                lookup.is_2m = tag_2m_q[i];
                lookup.is_1g = tag_1g_q[i];
            end
        end
    end

    // --------------------
    // replacement
    // --------------------
    // scan from the top down so the lowest invalid slot wins
    always_comb begin
        has_free = 1'b0;
        free_idx = '0;
        for (int i = DTLB_ENTRIES - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                has_free = 1'b1;
                free_idx = IDX_W'(i);
            end
        end
    end

    assign wr_idx = has_free ? free_idx : rr_ptr_q;

    // flush takes priority over a refill in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            rr_ptr_q <= '0;
        end else if (flush_tlb_i) begin
            valid_q  <= '0;
            rr_ptr_q <= '0;
        end else if (update_valid_i) begin
            valid_q[wr_idx] <= 1'b1;
            // pointer only moves when it picked the victim
            if (!has_free) begin
                rr_ptr_q <= (rr_ptr_q == IDX_W'(DTLB_ENTRIES - 1)) ? '0 : rr_ptr_q + IDX_W'(1);
            end
        end
    end

    // tag and pte payload
    always_ff @(posedge clk_i) begin
        if (update_valid_i && !flush_tlb_i) begin
            tag_vpn_q[wr_idx]  <= update_vpn_i;
            tag_asid_q[wr_idx] <= update_asid_i;
            tag_2m_q[wr_idx]   <= update_is_2m_i;
            tag_1g_q[wr_idx]   <= update_is_1g_i;
            pte_q[wr_idx]      <= update_pte_i;
        end
    end

    // --------------------
    // checks
    // --------------------
    // refills never place overlapping pages
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        lookup.access |-> $onehot0(match))
        else $error("dtlb: more than one entry matches a lookup");

    // a page is never both 2M and 1G
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        update_valid_i |-> !(update_is_2m_i && update_is_1g_i))
        else $error("dtlb: refill with both superpage flags set");

endmodule

// File: hdl/lsu_xlat_stage.sv
// --------------------
// load/store address translation, one registered stage after the TLB
// builds the physical address and selects misaligned or page fault causes
// --------------------
`timescale 1ns/10ps

module lsu_xlat_stage (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                en_translation_i,
    // cycle 0 request
    input  logic                lsu_req_i,
    input  mmu_pkg::vaddr_t     lsu_vaddr_i,
    input  logic                lsu_is_store_i,
    input  logic                misaligned_i,
    // privilege state
    input  mmu_pkg::priv_lvl_t  priv_lvl_i,
    input  logic                sum_i,
    tlb_lookup_if.stage         lookup,
    // cycle 0 outputs
    output logic                lsu_dtlb_hit_o,
    output logic                dtlb_miss_o,
    // cycle 1 outputs
    output logic                lsu_valid_o,
    output mmu_pkg::paddr_t     lsu_paddr_o,
    output logic                lsu_exception_valid_o,
    output mmu_pkg::cause_t     lsu_exception_cause_o,
    output mmu_pkg::vaddr_t     lsu_exception_tval_o
);

    localparam int unsigned OFS_W = mmu_pkg::PAGE_OFFSET_W;
    localparam int unsigned LVL_W = mmu_pkg::VPN_LEVEL_W;
    localparam int unsigned PA_W  = mmu_pkg::PADDR_W;

    // control state
    logic            lsu_req_q;
    logic            misaligned_q;
    logic            hit_q;
    // payload
    mmu_pkg::vaddr_t vaddr_q;
    logic            is_store_q;
    mmu_pkg::pte_t   pte_q;
    logic            is_2m_q;
    logic            is_1g_q;

    logic            access_err;
    logic            translate;

    // --------------------
    // cycle 0
    // --------------------
    // bare mode always reports a hit
    assign lsu_dtlb_hit_o = en_translation_i ? lookup.hit : 1'b1;
    // perf counter pulse, only meaningful while translating
    assign dtlb_miss_o    = lsu_req_i && en_translation_i && !lookup.hit;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lsu_req_q    <= 1'b0;
            misaligned_q <= 1'b0;
            hit_q        <= 1'b0;
        end else begin
            lsu_req_q    <= lsu_req_i;
            // strobe is ignored without a request
            misaligned_q <= misaligned_i && lsu_req_i;
            hit_q        <= lookup.hit;
        end
    end

    always_ff @(posedge clk_i) begin
        vaddr_q    <= lsu_vaddr_i;
        is_store_q <= lsu_is_store_i;
        pte_q      <= lookup.pte;
        is_2m_q    <= lookup.is_2m;
        is_1g_q    <= lookup.is_1g;
    end

    // --------------------
    // cycle 1
    // --------------------
    // a misaligned access skips translation entirely
    assign translate = en_translation_i && !misaligned_q;

    // user page from S needs SUM, non-user page from U is never allowed
    assign access_err = ((priv_lvl_i == mmu_pkg::PRIV_LVL_U) && !pte_q.u)
                     || ((priv_lvl_i == mmu_pkg::PRIV_LVL_S) && pte_q.u && !sum_i);

    // miss keeps valid low, the core refills and retries
    assign lsu_valid_o = lsu_req_q && (!en_translation_i || misaligned_q || hit_q);

    always_comb begin
        // pass-through by default
        lsu_paddr_o = vaddr_q[PA_W-1:0];
        if (translate) begin
            lsu_paddr_o = {pte_q.ppn, vaddr_q[OFS_W-1:0]};
            // megapage keeps vpn[0] from the virtual address
            if (is_2m_q) begin
                lsu_paddr_o[OFS_W+LVL_W-1:OFS_W] = vaddr_q[OFS_W+LVL_W-1:OFS_W];
            end
            // gigapage keeps vpn[1] and vpn[0]
            if (is_1g_q) begin
                lsu_paddr_o[OFS_W+2*LVL_W-1:OFS_W] = vaddr_q[OFS_W+2*LVL_W-1:OFS_W];
            end
        end
    end

    // exception priority: misaligned, then store fault, then load fault
    always_comb begin
        lsu_exception_valid_o = 1'b0;
        lsu_exception_cause_o = '0;
        if (lsu_req_q) begin
            if (misaligned_q) begin
                lsu_exception_valid_o = 1'b1;
                lsu_exception_cause_o = is_store_q ? mmu_pkg::STORE_ADDR_MISALIGNED
                                                   : mmu_pkg::LOAD_ADDR_MISALIGNED;
            end else if (en_translation_i && hit_q) begin
                if (is_store_q) begin
                    // dirty bit must already be set, no hardware update
                    if (!pte_q.w || !pte_q.d || access_err) begin
                        lsu_exception_valid_o = 1'b1;
                        lsu_exception_cause_o = mmu_pkg::STORE_PAGE_FAULT;
                    end
                end else if (access_err) begin
                    lsu_exception_valid_o = 1'b1;
                    lsu_exception_cause_o = mmu_pkg::LOAD_PAGE_FAULT;
                end
            end
        end
    end

    // faulting address is always the one of the request
    assign lsu_exception_tval_o = vaddr_q;

    // --------------------
    // checks
    // --------------------
    // fixed latency of one cycle
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_valid_o |-> $past(lsu_req_i))
        else $error("lsu_xlat_stage: valid without a request one cycle earlier");

    // an exception is only reported on a valid translation
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_exception_valid_o |-> lsu_valid_o)
        else $error("lsu_xlat_stage: exception without valid");

endmodule

// File: hdl/data_mmu.sv
// --------------------
// data-side SV39 MMU top level, the TLB and the load/store stage
// refill comes from the core, a miss just withholds valid
// --------------------
`timescale 1ns/10ps

module data_mmu #(
    parameter int unsigned DTLB_ENTRIES = 4,
    parameter int unsigned ASID_WIDTH   = 16
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_tlb_i,
    input  logic                en_translation_i,
    // load/store request
    input  logic                lsu_req_i,
    input  mmu_pkg::vaddr_t     lsu_vaddr_i,
    input  logic                lsu_is_store_i,
    input  logic                misaligned_i,
    // privilege and address space
    input  mmu_pkg::priv_lvl_t  priv_lvl_i,
    input  logic                sum_i,
    input  mmu_pkg::asid_t      asid_i,
    // tlb refill strobe
    input  logic                update_valid_i,
    input  mmu_pkg::vpn_t       update_vpn_i,
    input  mmu_pkg::asid_t      update_asid_i,
    input  mmu_pkg::pte_t       update_pte_i,
    input  logic                update_is_2m_i,
    input  logic                update_is_1g_i,
    // cycle 0
    output logic                lsu_dtlb_hit_o,
    output logic                dtlb_miss_o,
    // cycle 1
    output logic                lsu_valid_o,
    output mmu_pkg::paddr_t     lsu_paddr_o,
    output logic                lsu_exception_valid_o,
    output mmu_pkg::cause_t     lsu_exception_cause_o,
    output mmu_pkg::vaddr_t     lsu_exception_tval_o
);

    tlb_lookup_if dtlb_lookup ();

    // every lsu request looks up the tlb
    assign dtlb_lookup.access = lsu_req_i;
    assign dtlb_lookup.vaddr  = lsu_vaddr_i;
    assign dtlb_lookup.asid   = asid_i;

    dtlb #(
        .DTLB_ENTRIES   ( DTLB_ENTRIES   ),
        .ASID_WIDTH     ( ASID_WIDTH     )
    ) i_dtlb (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .flush_tlb_i    ( flush_tlb_i    ),
        .update_valid_i ( update_valid_i ),
        .update_vpn_i   ( update_vpn_i   ),
        .update_asid_i  ( update_asid_i  ),
        .update_pte_i   ( update_pte_i   ),
        .update_is_2m_i ( update_is_2m_i ),
        .update_is_1g_i ( update_is_1g_i ),
        .lookup         ( dtlb_lookup    )
    );

    lsu_xlat_stage i_lsu_xlat_stage (
        .clk_i                 ( clk_i                 ),
        .rst_ni                ( rst_ni                ),
        .en_translation_i      ( en_translation_i      ),
        .lsu_req_i             ( lsu_req_i             ),
        .lsu_vaddr_i           ( lsu_vaddr_i           ),
        .lsu_is_store_i        ( lsu_is_store_i        ),
        .misaligned_i          ( misaligned_i          ),
        .priv_lvl_i            ( priv_lvl_i            ),
        .sum_i                 ( sum_i                 ),
        .lookup                ( dtlb_lookup           ),
        .lsu_dtlb_hit_o        ( lsu_dtlb_hit_o        ),
        .dtlb_miss_o           ( dtlb_miss_o           ),
        .lsu_valid_o           ( lsu_valid_o           ),
        .lsu_paddr_o           ( lsu_paddr_o           ),
        .lsu_exception_valid_o ( lsu_exception_valid_o ),
        .lsu_exception_cause_o ( lsu_exception_cause_o ),
        .lsu_exception_tval_o  ( lsu_exception_tval_o  )
    );

endmodule

// File: verif/data_mmu_props.svh
// --------------------
// checking assertions of the data MMU testbench
// compares DUT outputs against the expected values set by the stimulus
// --------------------
`ifndef DATA_MMU_PROPS_SVH
`define DATA_MMU_PROPS_SVH

// cycle 0 checks in the same cycle as the request
assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk0 |-> (lsu_dtlb_hit_o == exp_hit))
    else begin
        $display("** Error %0s hit expected %0b actual %0b",
                 test_name, exp_hit, $sampled(lsu_dtlb_hit_o));
        $display("=== FAIL ===");
        $fatal(1);
    end

assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk0 |-> (dtlb_miss_o == exp_miss))
    else begin
        $display("** Error %0s miss expected %0b actual %0b",
                 test_name, exp_miss, $sampled(dtlb_miss_o));
        $display("=== FAIL ===");
        $fatal(1);
    end

// --------------------
// cycle 1 result
// --------------------
assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk1 |-> (lsu_valid_o == exp_valid))
    else begin
        $display("** Error %0s valid expected %0b actual %0b",
                 test_name, exp_valid, $sampled(lsu_valid_o));
        $display("=== FAIL ===");
        $fatal(1);
    end

assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk1 |-> (lsu_exception_valid_o == exp_exc))
    else begin
        $display("** Error %0s exception expected %0b actual %0b",
                 test_name, exp_exc, $sampled(lsu_exception_valid_o));
        $display("=== FAIL ===");
        $fatal(1);
    end

// paddr only means something on a clean translation
assert property (@(posedge clk_i) disable iff (!rst_ni)
    (chk1 && exp_valid && !exp_exc) |-> (lsu_paddr_o == exp_paddr))
    else begin
        $display("** Error %0s paddr expected %h actual %h",
                 test_name, exp_paddr, $sampled(lsu_paddr_o));
        $display("=== FAIL ===");
        $fatal(1);
    end

assert property (@(posedge clk_i) disable iff (!rst_ni)
    (chk1 && exp_exc) |-> (lsu_exception_cause_o == exp_cause))
    else begin
        $display("** Error %0s cause expected %0d actual %0d",
                 test_name, exp_cause, $sampled(lsu_exception_cause_o));
        $display("=== FAIL ===");
        $fatal(1);
    end

assert property (@(posedge clk_i) disable iff (!rst_ni)
    (chk1 && exp_exc) |-> (lsu_exception_tval_o == exp_tval))
    else begin
        $display("** Error %0s tval expected %h actual %h",
                 test_name, exp_tval, $sampled(lsu_exception_tval_o));
        $display("=== FAIL ===");
        $fatal(1);
    end

`endif

// File: verif/tb_data_mmu.sv
// --------------------
// testbench of the data MMU that drives refills and load/store requests
// --------------------
`timescale 1ns/10ps

module tb_data_mmu;

    localparam int unsigned ENTRIES = 4;
    // flags d a g u x w r v
    localparam logic [7:0] FL_RW     = 8'b1100_0111;
    localparam logic [7:0] FL_RO     = 8'b1100_0011;
    localparam logic [7:0] FL_CLEAN  = 8'b0100_0111;
    localparam logic [7:0] FL_USER   = 8'b1101_0111;
    localparam logic [7:0] FL_GLOBAL = 8'b1110_0111;

    logic clk_i, rst_ni, flush_tlb_i, en_translation_i;
    logic lsu_req_i, lsu_is_store_i, misaligned_i, sum_i;
    mmu_pkg::vaddr_t    lsu_vaddr_i;
    mmu_pkg::priv_lvl_t priv_lvl_i;
    mmu_pkg::asid_t     asid_i, update_asid_i;
    logic               update_valid_i, update_is_2m_i, update_is_1g_i;
    mmu_pkg::vpn_t      update_vpn_i;
    mmu_pkg::pte_t      update_pte_i;
    logic lsu_dtlb_hit_o, dtlb_miss_o, lsu_valid_o, lsu_exception_valid_o;
    mmu_pkg::paddr_t    lsu_paddr_o;
    mmu_pkg::cause_t    lsu_exception_cause_o;
    mmu_pkg::vaddr_t    lsu_exception_tval_o;

    // expected values read by the assertions
    logic chk0, chk1, exp_hit, exp_miss, exp_valid, exp_exc;
    mmu_pkg::cause_t exp_cause;
    mmu_pkg::paddr_t exp_paddr;
    mmu_pkg::vaddr_t exp_tval;
    string           test_name;
    logic [31:0]     lfsr;
    mmu_pkg::vpn_t   vpn_a, vpn_b, vpn_c, vpn_d;
    mmu_pkg::ppn_t   ppn_a, ppn_b, ppn_c, ppn_d;
    mmu_pkg::vpn_t   rep_vpn [ENTRIES+1];
    mmu_pkg::ppn_t   rep_ppn [ENTRIES+1];

    data_mmu #(.DTLB_ENTRIES(ENTRIES), .ASID_WIDTH(16)) i_dut (.*);

    `include "data_mmu_props.svh"

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // run limit in case the sequence stalls
    initial begin
        repeat (2000) @(posedge clk_i);
        $display("run did not finish within 2000 cycles");
        $display("=== FAIL ===");
        $fatal(1);
    end

    // galois lfsr stepped once per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r[i] = lfsr[0];
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    // page vpn with a chosen top level so pages never overlap
    function automatic mmu_pkg::vpn_t page_vpn(input logic [8:0] top);
        logic [63:0] r;
        r = rand_bits(18);
        return {top, r[17:0]};
    endfunction

    // ppn above the page offset with the low vpn levels of a superpage kept from va
    function automatic mmu_pkg::paddr_t xlat_paddr(input mmu_pkg::ppn_t ppn,
            input mmu_pkg::vaddr_t va, input int sz);
        mmu_pkg::paddr_t pa;
        pa = {ppn, va[11:0]};
        if (sz == 1) pa[20:12] = va[20:12];
        if (sz == 2) pa[29:12] = va[29:12];
        return pa;
    endfunction

    task automatic tick();
        @(posedge clk_i);
        #5;
    endtask

    task automatic refill(input mmu_pkg::vpn_t vpn, input mmu_pkg::asid_t asid,
            input mmu_pkg::ppn_t ppn, input logic [7:0] flags, input int sz);
        update_valid_i = 1'b1;
        update_vpn_i   = vpn;
        update_asid_i  = asid;
        update_pte_i   = {ppn, flags};
        update_is_2m_i = (sz == 1);
        update_is_1g_i = (sz == 2);
        tick();
        update_valid_i = 1'b0;
    endtask

    task automatic flush();
        flush_tlb_i = 1'b1;
        tick();
        flush_tlb_i = 1'b0;
    endtask

    // request in cycle 0 and its result checked in cycle 1
    task automatic do_access(input string name, input mmu_pkg::vaddr_t va,
            input logic store, input logic mis, input logic hit, input logic valid,
            input logic exc, input mmu_pkg::cause_t cause, input mmu_pkg::paddr_t pa);
        test_name      = name;
        lsu_req_i      = 1'b1;
        lsu_vaddr_i    = va;
        lsu_is_store_i = store;
        misaligned_i   = mis;
        exp_hit   = hit;
        exp_miss  = en_translation_i && !hit;
        exp_valid = valid;
        exp_exc   = exc;
        exp_cause = cause;
        exp_paddr = pa;
        exp_tval  = va;
        chk0      = 1'b1;
        tick();
        lsu_req_i    = 1'b0;
        misaligned_i = 1'b0;
        chk0         = 1'b0;
        chk1         = 1'b1;
        tick();
        chk1 = 1'b0;
    endtask

    // access inside a mapped page with random offset and low levels
    task automatic check_page(input string name, input mmu_pkg::vpn_t vpn,
            input mmu_pkg::ppn_t ppn, input int sz, input logic store,
            input logic exc, input mmu_pkg::cause_t cause);
        mmu_pkg::vpn_t   v;
        mmu_pkg::vaddr_t va;
        logic [63:0]     r;
        v = vpn;
        r = rand_bits(18);
        if (sz == 1) v[8:0] = r[8:0];
        if (sz == 2) v[17:0] = r[17:0];
        r  = rand_bits(12);
        va = {25'd0, v, r[11:0]};
        do_access(name, va, store, 1'b0, 1'b1, 1'b1, exc, cause, xlat_paddr(ppn, va, sz));
    endtask

    task automatic miss_page(input string name, input mmu_pkg::vpn_t vpn);
        do_access(name, {25'd0, vpn, 12'h010}, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
    endtask

    initial begin
        lfsr = 32'h34a5e438;
        {rst_ni, flush_tlb_i, en_translation_i, lsu_req_i, lsu_is_store_i} = '0;
        {misaligned_i, sum_i, update_valid_i, update_is_2m_i, update_is_1g_i} = '0;
        {chk0, chk1, exp_hit, exp_miss, exp_valid, exp_exc} = '0;
        lsu_vaddr_i = '0;
        priv_lvl_i = mmu_pkg::PRIV_LVL_S;
        asid_i = 16'd5;
        update_asid_i = '0;
        update_vpn_i = '0;
        update_pte_i = '0;
        exp_cause = '0;
        exp_paddr = '0;
        exp_tval = '0;
        test_name = "reset";
        repeat (3) @(posedge clk_i);
        #5;
        rst_ni = 1'b1;
        tick();

        // bare pass-through
        lsu_vaddr_i = rand_bits(64);
        do_access("bare", lsu_vaddr_i, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, '0, lsu_vaddr_i[55:0]);
        en_translation_i = 1'b1;
        miss_page("empty_miss", page_vpn(9'd1));

        // one page of each size
        vpn_a = page_vpn(9'd1);
        vpn_b = page_vpn(9'd2);
        vpn_c = page_vpn(9'd3);
        ppn_a = mmu_pkg::ppn_t'(rand_bits(44));
        ppn_b = mmu_pkg::ppn_t'(rand_bits(44));
        ppn_c = mmu_pkg::ppn_t'(rand_bits(44));
        refill(vpn_a, 16'd5, ppn_a, FL_RW, 0);
        refill(vpn_b, 16'd5, ppn_b, FL_RW, 1);
        refill(vpn_c, 16'd5, ppn_c, FL_RW, 2);
        check_page("hit_4k", vpn_a, ppn_a, 0, 1'b0, 1'b0, '0);
        check_page("hit_4k_store", vpn_a, ppn_a, 0, 1'b1, 1'b0, '0);
        check_page("hit_2m", vpn_b, ppn_b, 1, 1'b0, 1'b0, '0);
        check_page("hit_1g", vpn_c, ppn_c, 2, 1'b1, 1'b0, '0);

        // permission faults
        flush();
        vpn_a = page_vpn(9'd4);
        vpn_b = page_vpn(9'd5);
        vpn_c = page_vpn(9'd6);
        refill(vpn_a, 16'd5, ppn_a, FL_RO, 0);
        refill(vpn_b, 16'd5, ppn_b, FL_CLEAN, 0);
        refill(vpn_c, 16'd5, ppn_c, FL_USER, 0);
        check_page("store_ro", vpn_a, ppn_a, 0, 1'b1, 1'b1, mmu_pkg::STORE_PAGE_FAULT);
        check_page("store_clean", vpn_b, ppn_b, 0, 1'b1, 1'b1, mmu_pkg::STORE_PAGE_FAULT);
        priv_lvl_i = mmu_pkg::PRIV_LVL_U;
        check_page("u_load_s_page", vpn_a, ppn_a, 0, 1'b0, 1'b1, mmu_pkg::LOAD_PAGE_FAULT);
        priv_lvl_i = mmu_pkg::PRIV_LVL_S;
        check_page("s_load_no_sum", vpn_c, ppn_c, 0, 1'b0, 1'b1, mmu_pkg::LOAD_PAGE_FAULT);
        sum_i = 1'b1;
        check_page("s_load_sum", vpn_c, ppn_c, 0, 1'b0, 1'b0, '0);
        sum_i = 1'b0;

        // asid match, global pages and flush
        flush();
        vpn_d = page_vpn(9'd7);
        ppn_d = mmu_pkg::ppn_t'(rand_bits(44));
        refill(vpn_c, 16'd5, ppn_c, FL_RW, 0);
        refill(vpn_d, 16'd5, ppn_d, FL_GLOBAL, 0);
        asid_i = 16'd7;
        miss_page("asid_mismatch", vpn_c);
        check_page("global_hit", vpn_d, ppn_d, 0, 1'b0, 1'b0, '0);
        asid_i = 16'd5;
        check_page("asid_hit", vpn_c, ppn_c, 0, 1'b0, 1'b0, '0);
        flush();
        miss_page("after_flush", vpn_c);

        // misaligned overrides a miss
        do_access("misaligned_load", {25'd0, vpn_d, 12'h003}, 1'b0, 1'b1, 1'b0, 1'b1,
                  1'b1, mmu_pkg::LOAD_ADDR_MISALIGNED, '0);
        do_access("misaligned_store", {25'd0, vpn_d, 12'h005}, 1'b1, 1'b1, 1'b0, 1'b1,
                  1'b1, mmu_pkg::STORE_ADDR_MISALIGNED, '0);

        // one more page than entries evicts the first
        for (int i = 0; i <= ENTRIES; i++) begin
            rep_vpn[i] = page_vpn(9'(10 + i));
            rep_ppn[i] = mmu_pkg::ppn_t'(rand_bits(44));
            refill(rep_vpn[i], 16'd5, rep_ppn[i], FL_RW, 0);
        end
        miss_page("evicted", rep_vpn[0]);
        for (int i = 1; i <= ENTRIES; i++) begin
            check_page("kept", rep_vpn[i], rep_ppn[i], 0, 1'b0, 1'b0, '0);
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: src.f
+incdir+verif
hdl/mmu_pkg.sv
hdl/tlb_lookup_if.sv
hdl/dtlb.sv
hdl/lsu_xlat_stage.sv
hdl/data_mmu.sv
verif/tb_data_mmu.sv

// File: run.sh
#!/bin/sh
# build and run the data MMU testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
    --top-module tb_data_mmu \
    -f src.f \
    -o sim_tb_data_mmu
./obj_dir/sim_tb_data_mmu
